// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       = tbMipsPipeline
FLIST     = flist.f
SIMARGS   = +verilator+error+limit+100
PASS_MSG  = Simulation passed

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) $(SIMARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir

// ==== bench/mipsPipeline_assert.sv ====
module mipsPipeline_assert (
	input logic DCACHE_stall,
	input logic rst_n,
	input logic icacheRen,
	input logic [mipsPkg::addrWidth-1:0] icacheAddr,
	input logic icacheStall,
	input logic dcacheRen,
	input logic dcacheWen,
	input logic [mipsPkg::addrWidth-1:0] dcacheAddr,
	input logic [mipsPkg::dataWidth-1:0] dcacheWdata,
	input logic dcacheHold
);
	timeunit 1ns;
	timeprecision 100ps;
	import mipsPkg::*;

	localparam int storeTotal = 13;

	int errCount = 0;
	logic stall, prevStall;
	logic [63:0] portNow, prevPort;

	assign stall = icacheStall || dcacheHold;
	assign portNow = {dcacheRen, dcacheWen, dcacheAddr, dcacheWdata};

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			prevStall <= 1'b0;
			prevPort <= '0;
		end else begin
			prevStall <= stall;
			prevPort <= portNow;
		end
	end

	// r1 = 5, r2 = -3, slt compares unsigned
	function automatic logic [31:0] expectedStore(input logic [addrWidth-1:0] a);
		case (a)
			0: return 32'h0000_0002;	// add
			1: return 32'h0000_0008;	// sub
			2: return 32'h0000_0005;	// and
			3: return 32'hffff_fffd;	// or
			4: return 32'hffff_fff8;	// xor
			5: return 32'h0000_0002;	// nor
			6: return 32'h0000_0001;	// slt
			7: return 32'h0000_f0ff;	// andi then ori
			8: return 32'h0000_0001;	// slti against all ones
			9: return 32'h1000_0335;	// load word 48 plus 5
			10: return 32'h0000_0007;	// after untaken beq
			11: return 32'h0000_0005;	// after taken beq and j
			12: return 32'h1000_0341;	// load word 49
			default: return 32'hdead_beef;
		endcase
	endfunction

	resetState: assert property (@(posedge DCACHE_stall)
		!rst_n |-> !dcacheRen && !dcacheWen && !icacheRen && icacheAddr == '0)
	else begin
		errCount++;
		$error("** Error reset_state: expected 0 0 0 0, actual %b %b %b %h",
			$sampled(dcacheRen), $sampled(dcacheWen), $sampled(icacheRen),
			$sampled(icacheAddr));
	end

	storeRange: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		dcacheWen && !dcacheHold |-> dcacheAddr < storeTotal)
	else begin
		errCount++;
		$error("** Error store_range: a store reached word %0d, which must not be written",
			$sampled(dcacheAddr));
	end

	storeValue: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		dcacheWen && !dcacheHold && dcacheAddr < storeTotal
		|-> dcacheWdata == expectedStore(dcacheAddr))
	else begin
		errCount++;
		$error("** Error store_value[%0d]: expected %h, actual %h", $sampled(dcacheAddr),
			expectedStore($sampled(dcacheAddr)), $sampled(dcacheWdata));
	end

	portHold: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		prevStall |-> portNow == prevPort)
	else begin
		errCount++;
		$error("** Error port_hold: expected %h, actual %h", $sampled(prevPort),
			$sampled(portNow));
	end

	singleAccess: assert property (@(posedge DCACHE_stall) disable iff (!rst_n)
		!(dcacheRen && dcacheWen))
	else begin
		errCount++;
		$error("** Error single_access: dcacheRen and dcacheWen are high together");
	end

endmodule

bind mipsPipeline mipsPipeline_assert portChecks (
	.DCACHE_stall(DCACHE_stall), .rst_n(rst_n), .icacheRen(icacheRen),
	.icacheAddr(icacheAddr), .icacheStall(icacheStall), .dcacheRen(dcacheRen),
	.dcacheWen(dcacheWen), .dcacheAddr(dcacheAddr), .dcacheWdata(dcacheWdata),
	.dcacheHold(dcacheHold)
);

// ==== bench/tbMipsPipeline.sv ====
module tbMipsPipeline;
	timeunit 1ns;
	timeprecision 100ps;
	import mipsPkg::*;

	localparam logic [31:0] seed = 32'h47e7_47d7;
	localparam int progLength = 36;
	localparam int storeTotal = 13;
	localparam int timeoutCycles = progLength * 4 + 256;	// margin for hazards and stalls

	logic DCACHE_stall = 1'b0;
	logic rst_n;
	logic icacheRen;
	logic [addrWidth-1:0] icacheAddr;
	logic [dataWidth-1:0] icacheRdata;
	logic icacheStall;
	logic dcacheRen;
	logic dcacheWen;
	logic [addrWidth-1:0] dcacheAddr;
	logic [dataWidth-1:0] dcacheWdata;
	logic [dataWidth-1:0] dcacheRdata;
	logic dcacheHold;

	logic [dataWidth-1:0] rom [64];
	logic [dataWidth-1:0] ram [64];
	logic [31:0] rngState;
	int cycles;
	int storesSeen;

	mipsPipeline uut (
		.DCACHE_stall(DCACHE_stall), .rst_n(rst_n),
		.icacheRen(icacheRen), .icacheAddr(icacheAddr), .icacheRdata(icacheRdata),
		.icacheStall(icacheStall), .dcacheRen(dcacheRen), .dcacheWen(dcacheWen),
		.dcacheAddr(dcacheAddr), .dcacheWdata(dcacheWdata), .dcacheRdata(dcacheRdata),
		.dcacheHold(dcacheHold)
	);

	always #2 DCACHE_stall = ~DCACHE_stall;

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] encodeR(input functE fn, input int rd, input int rs,
		input int rt);
		return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input opcodeE op, input int rt, input int rs,
		input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] encodeJ(input int word);
		return {opJ, 26'(word)};
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < 64; i++)
			rom[i] = '0;
		rom[0] = encodeI(opAddi, 1, 0, 5);
		rom[1] = encodeI(opAddi, 2, 0, -3);
		rom[2] = encodeR(fnAdd, 3, 1, 2);	// r2 from MEM, r1 from WB
		rom[3] = encodeI(opSw, 3, 0, 0);
		rom[4] = encodeR(fnSub, 4, 1, 2);
		rom[5] = encodeI(opSw, 4, 0, 4);
		rom[6] = encodeR(fnAnd, 5, 1, 2);
		rom[7] = encodeI(opSw, 5, 0, 8);
		rom[8] = encodeR(fnOr, 6, 1, 2);
		rom[9] = encodeI(opSw, 6, 0, 12);
		rom[10] = encodeR(fnXor, 7, 1, 2);
		rom[11] = encodeI(opSw, 7, 0, 16);
		rom[12] = encodeR(fnNor, 8, 1, 2);
		rom[13] = encodeI(opSw, 8, 0, 20);
		rom[14] = encodeR(fnSlt, 9, 1, 2);
		rom[15] = encodeI(opSw, 9, 0, 24);
		rom[16] = encodeI(opAndi, 10, 2, 16'hf0f0);
		rom[17] = encodeI(opOri, 11, 10, 16'h000f);
		rom[18] = encodeI(opSw, 11, 0, 28);
		rom[19] = encodeI(opSlti, 12, 1, -1);
		rom[20] = encodeI(opSw, 12, 0, 32);
		rom[21] = encodeI(opLw, 13, 0, 192);	// data word 48
		rom[22] = encodeR(fnAdd, 14, 13, 1);	// load-use bubble
		rom[23] = encodeI(opSw, 14, 0, 36);
		rom[24] = encodeI(opAddi, 15, 0, 7);
		rom[25] = encodeI(opBeq, 1, 15, 1);	// not taken, waits on r15
		rom[26] = encodeI(opSw, 15, 0, 40);
		rom[27] = encodeI(opAddi, 16, 0, 5);
		rom[28] = encodeI(opBeq, 1, 16, 1);	// taken to word 30
		rom[29] = encodeI(opSw, 15, 0, 120);	// marker, must be skipped
		rom[30] = encodeJ(32);
		rom[31] = encodeI(opSw, 16, 0, 124);	// marker, must be skipped
		rom[32] = encodeI(opSw, 16, 0, 44);
		rom[33] = encodeI(opLw, 17, 0, 196);
		rom[34] = encodeI(opSw, 17, 0, 48);	// load-use on store data
		rom[35] = encodeJ(35);	// park here
	endtask

	// called on each falling edge
	task automatic serviceCycle();
		rngState = nextRand(rngState);
		icacheStall = rngState[31:30] == 2'b00 && rngState[29];
		dcacheHold = rngState[31:30] == 2'b00 && !rngState[29];
		if (dcacheWen && !dcacheHold)
			ram[dcacheAddr[5:0]] = dcacheWdata;
		if (dcacheWen && !dcacheHold && !icacheStall)
			storesSeen++;	// store taken at the coming edge
		icacheRdata = icacheRen ? rom[icacheAddr[5:0]] : '0;
		dcacheRdata = dcacheRen ? ram[dcacheAddr[5:0]] : '0;
		cycles++;
	endtask

	initial begin
		rst_n = 1'b0;
		icacheStall = 1'b0;
		dcacheHold = 1'b0;
		icacheRdata = '0;
		dcacheRdata = '0;
		rngState = seed;
		cycles = 0;
		storesSeen = 0;
		loadProgram();
		for (int i = 0; i < 64; i++)
			ram[i] = 32'h1000_0000 + 32'(i) * 32'h11;
		repeat (5) @(negedge DCACHE_stall);
		rst_n = 1'b1;
		while (storesSeen < storeTotal && uut.portChecks.errCount == 0
			&& cycles < timeoutCycles) begin
			@(negedge DCACHE_stall);
			serviceCycle();
		end
		if (storesSeen == storeTotal)
			@(negedge DCACHE_stall);	// let the last store reach its edge
		if (uut.portChecks.errCount != 0 || storesSeen < storeTotal) begin
			$display("Simulation failed");
			if (uut.portChecks.errCount != 0)
				$fatal(1, "stopped at the first failing data port check");
			else
				$fatal(1, "timeout after %0d cycles, only %0d of %0d stores arrived",
					cycles, storesSeen, storeTotal);
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// ==== flist.f ====
hdl/mipsPkg.sv
hdl/pipeBus.sv
hdl/fetchStage.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/mipsPipeline.sv
bench/mipsPipeline_assert.sv
bench/tbMipsPipeline.sv

// ==== hdl/decodeStage.sv ====
module decodeStage (
	input  logic DCACHE_stall,
	input  logic rst_n,
	input  logic stall,
	input  logic [mipsPkg::dataWidth-1:0] instr,
	input  logic [mipsPkg::addrWidth-1:0] pcWord,
	input  logic [mipsPkg::dataWidth-1:0] rsData,
	input  logic [mipsPkg::dataWidth-1:0] rtData,
	idExBus.driver exBus,
	input  logic memRegWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] memDestIdx,
	output logic [mipsPkg::regAddrWidth-1:0] rsIdx,
	output logic [mipsPkg::regAddrWidth-1:0] rtIdx,
	output logic hazard,
	output logic redirect,
	output logic [mipsPkg::addrWidth-1:0] target
);
	import mipsPkg::*;

	opcodeE op;
	functE fn;
	aluOpE aluOpDec;
	srcBE srcBDec;
	logic memReadDec, memWriteDec, regWriteDec, memToRegDec;
	logic [regAddrWidth-1:0] destDec;
	logic usesRs, usesRt, isBeq, isJump;
	logic loadUse, exHit, memHit;
	logic [addrWidth-1:0] branchTarget, jumpTarget;

	assign op = opcodeE'(instr[31:26]);
	assign fn = functE'(instr[5:0]);
	assign rsIdx = instr[25:21];
	assign rtIdx = instr[20:16];

	always_comb begin
		aluOpDec = aluAdd;
		srcBDec = srcReg;
		memReadDec = 1'b0;
		memWriteDec = 1'b0;
		regWriteDec = 1'b0;
		memToRegDec = 1'b0;
		destDec = '0;
		usesRs = 1'b0;
		usesRt = 1'b0;
		isBeq = 1'b0;
		isJump = 1'b0;
		case (op)
			opRtype: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				destDec = instr[15:11];
				regWriteDec = 1'b1;
				case (fn)
					fnAdd: aluOpDec = aluAdd;
					fnSub: aluOpDec = aluSub;
					fnAnd: aluOpDec = aluAnd;
					fnOr:  aluOpDec = aluOr;
					fnXor: aluOpDec = aluXor;
					fnNor: aluOpDec = aluNor;
					fnSlt: aluOpDec = aluSlt;
					default: regWriteDec = 1'b0;	// nop and unsupported funct
				endcase
			end
			opLw: begin
				usesRs = 1'b1;
				srcBDec = srcSext;
				memReadDec = 1'b1;
				memToRegDec = 1'b1;
				regWriteDec = 1'b1;
				destDec = instr[20:16];
			end
			opSw: begin
				usesRs = 1'b1;
				usesRt = 1'b1;	// store data
				srcBDec = srcSext;
				memWriteDec = 1'b1;
			end
			opBeq: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				isBeq = 1'b1;
			end
			opAddi, opSlti, opAndi, opOri: begin
				usesRs = 1'b1;
				regWriteDec = 1'b1;
				destDec = instr[20:16];
				srcBDec = (op == opAndi || op == opOri) ? srcZext : srcSext;
				aluOpDec = (op == opSlti) ? aluSlt : (op == opAndi) ? aluAnd
					: (op == opOri) ? aluOr : aluAdd;
			end
			opJ: isJump = 1'b1;
			default: ;
		endcase
	end

	assign loadUse = exBus.memRead && exBus.destIdx != '0
		&& ((usesRs && exBus.destIdx == rsIdx) || (usesRt && exBus.destIdx == rtIdx));
	assign exHit = exBus.regWrite && exBus.destIdx != '0
		&& (exBus.destIdx == rsIdx || exBus.destIdx == rtIdx);
	assign memHit = memRegWrite && memDestIdx != '0
		&& (memDestIdx == rsIdx || memDestIdx == rtIdx);
	assign hazard = loadUse || (isBeq && (exHit || memHit));	// beq waits for WB

	assign branchTarget = pcWord + {{(addrWidth-immWidth){instr[15]}}, instr[15:0]};
	assign jumpTarget = {pcWord[addrWidth-1:26], instr[25:0]};
	assign redirect = !hazard && (isJump || (isBeq && rsData == rtData));
	assign target = isJump ? jumpTarget : branchTarget;

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			exBus.aluOp <= aluAdd;
			exBus.srcB <= srcReg;
			exBus.memRead <= 1'b0;
			exBus.memWrite <= 1'b0;
			exBus.regWrite <= 1'b0;
			exBus.memToReg <= 1'b0;
		end else if (!stall) begin
			exBus.aluOp <= hazard ? aluAdd : aluOpDec;	// bubble on hazard
			exBus.srcB <= hazard ? srcReg : srcBDec;
			exBus.memRead <= !hazard && memReadDec;
			exBus.memWrite <= !hazard && memWriteDec;
			exBus.regWrite <= !hazard && regWriteDec;
			exBus.memToReg <= !hazard && memToRegDec;
		end
	end

	always_ff @(posedge DCACHE_stall) begin
		if (!stall) begin
			exBus.rsIdx <= rsIdx;
			exBus.rtIdx <= rtIdx;
			exBus.destIdx <= destDec;
			exBus.rsData <= rsData;
			exBus.rtData <= rtData;
			exBus.imm <= instr[15:0];
		end
	end

endmodule

// ==== hdl/executeStage.sv ====
module executeStage (
	input  logic DCACHE_stall,
	input  logic rst_n,
	input  logic stall,
	idExBus.receiver exBus,
	exMemBus.driver memBus,
	input  logic [mipsPkg::dataWidth-1:0] memFwd,
	input  logic memRegWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] memDestIdx,
	input  logic wbWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] wbIdx,
	input  logic [mipsPkg::dataWidth-1:0] wbData
);
	import mipsPkg::*;

	logic [dataWidth-1:0] opA, regB, opB, aluOut;
	logic [dataWidth-1:0] immSext, immZext;

	// MEM wins over WB, r0 never forwarded
	always_comb begin
		if (memRegWrite && memDestIdx != '0 && memDestIdx == exBus.rsIdx)
			opA = memFwd;
		else if (wbWrite && wbIdx != '0 && wbIdx == exBus.rsIdx)
			opA = wbData;
		else
			opA = exBus.rsData;

		if (memRegWrite && memDestIdx != '0 && memDestIdx == exBus.rtIdx)
			regB = memFwd;
		else if (wbWrite && wbIdx != '0 && wbIdx == exBus.rtIdx)
			regB = wbData;
		else
			regB = exBus.rtData;
	end

	assign immSext = {{(dataWidth-immWidth){exBus.imm[immWidth-1]}}, exBus.imm};
	assign immZext = {{(dataWidth-immWidth){1'b0}}, exBus.imm};

	always_comb begin
		case (exBus.srcB)
			srcSext: opB = immSext;
			srcZext: opB = immZext;
			default: opB = regB;
		endcase
	end

	always_comb begin
		case (exBus.aluOp)
			aluAdd: aluOut = opA + opB;
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr:  aluOut = opA | opB;
			aluXor: aluOut = opA ^ opB;
			aluNor: aluOut = ~(opA | opB);
			aluSlt: aluOut = {{(dataWidth-1){1'b0}}, opA < opB};	// unsigned compare
			default: aluOut = '0;
		endcase
	end

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			memBus.memRead <= 1'b0;
			memBus.memWrite <= 1'b0;
			memBus.regWrite <= 1'b0;
			memBus.memToReg <= 1'b0;
		end else if (!stall) begin
			memBus.memRead <= exBus.memRead;
			memBus.memWrite <= exBus.memWrite;
			memBus.regWrite <= exBus.regWrite;
			memBus.memToReg <= exBus.memToReg;
		end
	end

	always_ff @(posedge DCACHE_stall) begin
		if (!stall) begin
			memBus.destIdx <= exBus.destIdx;
			memBus.aluResult <= aluOut;
			memBus.storeData <= regB;	// forwarded rt for sw
		end
	end

endmodule

// ==== hdl/fetchStage.sv ====
module fetchStage (
	input  logic DCACHE_stall,
	input  logic rst_n,
	input  logic stall,
	input  logic hazard,
	input  logic redirect,
	input  logic [mipsPkg::addrWidth-1:0] target,
	input  logic [mipsPkg::dataWidth-1:0] icacheRdata,
	output logic [mipsPkg::addrWidth-1:0] icacheAddr,
	output logic icacheRen,
	output logic [mipsPkg::dataWidth-1:0] instr
);
	import mipsPkg::*;

	logic [addrWidth-1:0] pc;

	assign icacheAddr = pc;

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			pc <= resetPc;
			icacheRen <= 1'b0;
			instr <= nopInstr;
		end else begin
			icacheRen <= 1'b1;	// first fetch one cycle after reset
			if (!stall) begin
				if (redirect) begin
					pc <= target;
					instr <= nopInstr;	// drop the slot behind beq/j
				end else if (icacheRen && !hazard) begin
					pc <= pc + 1'b1;
					instr <= icacheRdata;
				end
			end
		end
	end

endmodule

// ==== hdl/memoryStage.sv ====
module memoryStage (
	input  logic DCACHE_stall,
	input  logic rst_n,
	input  logic stall,
	exMemBus.receiver memBus,
	input  logic [mipsPkg::dataWidth-1:0] dcacheRdata,
	output logic dcacheRen,
	output logic dcacheWen,
	output logic [mipsPkg::addrWidth-1:0] dcacheAddr,
	output logic [mipsPkg::dataWidth-1:0] dcacheWdata,
	output logic [mipsPkg::dataWidth-1:0] memFwd,
	output logic memRegWrite,
	output logic [mipsPkg::regAddrWidth-1:0] memDestIdx,
	output logic wbWrite,
	output logic [mipsPkg::regAddrWidth-1:0] wbIdx,
	output logic [mipsPkg::dataWidth-1:0] wbData
);
	import mipsPkg::*;

	assign dcacheRen = memBus.memRead;
	assign dcacheWen = memBus.memWrite;
	assign dcacheAddr = memBus.aluResult[dataWidth-1:2];	// byte to word address
	assign dcacheWdata = memBus.storeData;

	assign memFwd = memBus.memToReg ? dcacheRdata : memBus.aluResult;
	assign memRegWrite = memBus.regWrite;
	assign memDestIdx = memBus.destIdx;

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n)
			wbWrite <= 1'b0;
		else if (!stall)
			wbWrite <= memBus.regWrite;
	end

	always_ff @(posedge DCACHE_stall) begin
		if (!stall) begin
			wbIdx <= memBus.destIdx;
			wbData <= memFwd;	// load data valid once hold drops
		end
	end

endmodule

// ==== hdl/mipsPipeline.sv ====
module mipsPipeline (
	input  logic DCACHE_stall,
	input  logic rst_n,
	output logic icacheRen,
	output logic [mipsPkg::addrWidth-1:0] icacheAddr,
	input  logic [mipsPkg::dataWidth-1:0] icacheRdata,
	input  logic icacheStall,
	output logic dcacheRen,
	output logic dcacheWen,
	output logic [mipsPkg::addrWidth-1:0] dcacheAddr,
	output logic [mipsPkg::dataWidth-1:0] dcacheWdata,
	input  logic [mipsPkg::dataWidth-1:0] dcacheRdata,
	input  logic dcacheHold
);
	import mipsPkg::*;

	logic stall;
	logic hazard, redirect;
	logic [addrWidth-1:0] target;
	logic [dataWidth-1:0] instr;
	logic [regAddrWidth-1:0] rsIdx, rtIdx;
	logic [dataWidth-1:0] rsData, rtData;
	logic [dataWidth-1:0] memFwd;
	logic memRegWrite;
	logic [regAddrWidth-1:0] memDestIdx;
	logic wbWrite;
	logic [regAddrWidth-1:0] wbIdx;
	logic [dataWidth-1:0] wbData;

	assign stall = icacheStall || dcacheHold;	// freezes every stage

	idExBus idEx ();
	exMemBus exMem ();

	fetchStage uFetch (
		.DCACHE_stall(DCACHE_stall), .rst_n(rst_n), .stall(stall), .hazard(hazard),
		.redirect(redirect), .target(target), .icacheRdata(icacheRdata),
		.icacheAddr(icacheAddr), .icacheRen(icacheRen), .instr(instr)
	);

	regFile uRegFile (
		.DCACHE_stall(DCACHE_stall), .rst_n(rst_n), .rsIdx(rsIdx), .rtIdx(rtIdx),
		.wbWrite(wbWrite), .wbIdx(wbIdx), .wbData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	decodeStage uDecode (
		.DCACHE_stall(DCACHE_stall), .rst_n(rst_n), .stall(stall), .instr(instr),
		.pcWord(icacheAddr), .rsData(rsData), .rtData(rtData), .exBus(idEx.driver),
		.memRegWrite(memRegWrite), .memDestIdx(memDestIdx), .rsIdx(rsIdx), .rtIdx(rtIdx),
		.hazard(hazard), .redirect(redirect), .target(target)
	);

	executeStage uExecute (
		.DCACHE_stall(DCACHE_stall), .rst_n(rst_n), .stall(stall),
		.exBus(idEx.receiver), .memBus(exMem.driver), .memFwd(memFwd),
		.memRegWrite(memRegWrite), .memDestIdx(memDestIdx),
		.wbWrite(wbWrite), .wbIdx(wbIdx), .wbData(wbData)
	);

	memoryStage uMemory (
		.DCACHE_stall(DCACHE_stall), .rst_n(rst_n), .stall(stall),
		.memBus(exMem.receiver), .dcacheRdata(dcacheRdata),
		.dcacheRen(dcacheRen), .dcacheWen(dcacheWen),
		.dcacheAddr(dcacheAddr), .dcacheWdata(dcacheWdata),
		.memFwd(memFwd), .memRegWrite(memRegWrite), .memDestIdx(memDestIdx),
		.wbWrite(wbWrite), .wbIdx(wbIdx), .wbData(wbData)
	);

endmodule

// ==== hdl/mipsPkg.sv ====
package mipsPkg;

	localparam int dataWidth = 32;
	localparam int addrWidth = 30;	// word address
	localparam int regAddrWidth = 5;
	localparam int regCount = 32;
	localparam int immWidth = 16;

	typedef enum logic [5:0] {
		opRtype = 6'd0,
		opJ     = 6'd2,
		opBeq   = 6'd4,
		opAddi  = 6'd8,
		opSlti  = 6'd10,
		opAndi  = 6'd12,
		opOri   = 6'd13,
		opLw    = 6'd35,
		opSw    = 6'd43
	} opcodeE;

	typedef enum logic [5:0] {
		fnAdd = 6'd32,
		fnSub = 6'd34,
		fnAnd = 6'd36,
		fnOr  = 6'd37,
		fnXor = 6'd38,
		fnNor = 6'd39,
		fnSlt = 6'd42
	} functE;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluNor,
		aluSlt
	} aluOpE;

	typedef enum logic [1:0] {
		srcReg,
		srcSext,
		srcZext
	} srcBE;

	localparam logic [addrWidth-1:0] resetPc = '0;
	localparam logic [dataWidth-1:0] nopInstr = '0;	// sll r0 treated as no-op

endpackage

// ==== hdl/pipeBus.sv ====
interface idExBus;
	import mipsPkg::*;

	aluOpE aluOp;
	srcBE srcB;
	logic memRead;
	logic memWrite;
	logic regWrite;
	logic memToReg;
	logic [regAddrWidth-1:0] rsIdx;
	logic [regAddrWidth-1:0] rtIdx;
	logic [regAddrWidth-1:0] destIdx;
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;
	logic [immWidth-1:0] imm;	// raw, extended in execute

	modport driver (output aluOp, srcB, memRead, memWrite, regWrite, memToReg,
		rsIdx, rtIdx, destIdx, rsData, rtData, imm);
	modport receiver (input aluOp, srcB, memRead, memWrite, regWrite, memToReg,
		rsIdx, rtIdx, destIdx, rsData, rtData, imm);

endinterface

interface exMemBus;
	import mipsPkg::*;

	logic memRead;
	logic memWrite;
	logic regWrite;
	logic memToReg;
	logic [regAddrWidth-1:0] destIdx;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] storeData;

	modport driver (output memRead, memWrite, regWrite, memToReg, destIdx,
		aluResult, storeData);
	modport receiver (input memRead, memWrite, regWrite, memToReg, destIdx,
		aluResult, storeData);

endinterface

// ==== hdl/regFile.sv ====
module regFile (
	input  logic DCACHE_stall,
	input  logic rst_n,
	input  logic [mipsPkg::regAddrWidth-1:0] rsIdx,
	input  logic [mipsPkg::regAddrWidth-1:0] rtIdx,
	input  logic wbWrite,
	input  logic [mipsPkg::regAddrWidth-1:0] wbIdx,
	input  logic [mipsPkg::dataWidth-1:0] wbData,
	output logic [mipsPkg::dataWidth-1:0] rsData,
	output logic [mipsPkg::dataWidth-1:0] rtData
);
	import mipsPkg::*;

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge DCACHE_stall or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (wbWrite && wbIdx != '0) begin
			regs[wbIdx] <= wbData;
		end
	end

	// write-through so decode sees this cycle's writeback
	assign rsData = (rsIdx == '0) ? '0 : (wbWrite && wbIdx == rsIdx) ? wbData : regs[rsIdx];
	assign rtData = (rtIdx == '0) ? '0 : (wbWrite && wbIdx == rtIdx) ? wbData : regs[rtIdx];

endmodule
